// ==== vlog.f ====
+incdir+logic
logic/periph_pkg.sv
logic/address_decoder.sv
logic/periph_regs.sv
logic/dsp_mult.sv
logic/pad_reader.sv
logic/bus_arbiter.sv
logic/periph_bus.sv
testbench/periph_checker.sv
testbench/periph_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the peripheral bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module periph_bus_tb -f vlog.f \
    -o periph_bus_sim > build.log 2>&1 \
    && ./obj_dir/periph_bus_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== testbench/periph_bus_tb.sv ====
/*
 * Peripheral bus testbench.
 * Plays the CPU, keeps a model of the registers and hands the
 * expected response of every access to the checker.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module periph_bus_tb;
    localparam int status_writes = 8;
    localparam int dsp_pairs = 12;
    localparam int pad_reads = 18;
    localparam int burst_len = 8;
    // test 4 stays well below 16 accesses
    localparam int total_accesses = 1 + 2 * status_writes + 3 * dsp_pairs
        + 2 * (2 + 3 * pad_reads) + 16 + burst_len;
    localparam int watchdog_cycles = 10 * total_accesses + 100;

    logic vdp_clk = 1'b0;
    logic vdp_reset = 1'b1;
    periph_pkg::bus_addr_t cpu_address = '0;
    logic cpu_mem_valid = 1'b0;
    logic [3:0] cpu_wstrb = 4'h0;
    periph_pkg::bus_word_t cpu_write_data = '0;
    periph_pkg::bus_word_t cpu_read_data;
    logic cpu_mem_ready;
    logic btn_left = 1'b0;
    logic btn_right = 1'b0;
    logic btn_b = 1'b0;
    logic led_r;
    logic led_b;

    logic req_start = 1'b0;
    logic exp_is_read = 1'b0;
    periph_pkg::bus_word_t exp_data = '0;
    int error_count;
    int check_count;
    int ready_count;

    // register model
    logic [1:0] status_model = `STATUS_RESET_VALUE;
    logic [1:0] pad_ctrl_model = 2'b00;
    logic [15:0] pad_model = '0;
    logic signed [15:0] op_a = '0;
    logic signed [15:0] op_b = '0;

    int seed = 32'hb264;
    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;
    int ready_base = 0;
    int n;
    int k;
    logic [31:0] rnd;
    logic [31:0] wa;
    logic [31:0] wb;
    periph_pkg::bus_addr_t status_addr;
    periph_pkg::bus_addr_t dsp_a_addr;
    periph_pkg::bus_addr_t dsp_b_addr;
    periph_pkg::bus_addr_t pad_addr;
    periph_pkg::bus_addr_t none_addr;

    periph_bus i_dut (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_address(cpu_address),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .cpu_read_data(cpu_read_data),
        .cpu_mem_ready(cpu_mem_ready),
        .btn_left(btn_left),
        .btn_right(btn_right),
        .btn_b(btn_b),
        .led_r(led_r),
        .led_b(led_b)
    );

    periph_checker i_checker (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .req_start(req_start),
        .exp_is_read(exp_is_read),
        .exp_data(exp_data),
        .exp_leds(status_model),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data),
        .led_r(led_r),
        .led_b(led_b),
        .error_count(error_count),
        .check_count(check_count),
        .ready_count(ready_count)
    );

    initial begin
        forever #2 vdp_clk = ~vdp_clk;
    end

    function automatic periph_pkg::bus_addr_t periph_address(input logic [1:0] field,
                                                             input logic [7:0] offset);
        periph_pkg::bus_addr_t addr;
        addr = '0;
        addr[`PERIPH_SEL_LSB +: 2] = field;
        addr[7:0] = offset;
        return addr;
    endfunction

    // reference read value from the model state
    function automatic periph_pkg::bus_word_t expected_read(input periph_pkg::bus_addr_t addr);
        case (addr[`PERIPH_SEL_LSB +: 2])
            `PERIPH_SEL_STATUS: return {30'b0, status_model};
            `PERIPH_SEL_DSP: return int'(op_a) * int'(op_b);
            `PERIPH_SEL_PAD: return {31'b0, pad_model[0]};
            default: return '0;
        endcase
    endfunction

    task automatic model_write(input periph_pkg::bus_addr_t addr,
                               input periph_pkg::bus_word_t wdata);
        case (addr[`PERIPH_SEL_LSB +: 2])
            `PERIPH_SEL_STATUS: status_model = wdata[1:0];
            `PERIPH_SEL_DSP: begin
                if (addr[`DSP_OPERAND_B_BIT]) begin
                    op_b = wdata[15:0];
                end else begin
                    op_a = wdata[15:0];
                end
            end
            `PERIPH_SEL_PAD: begin
                // latch wins over a rising clock
                if (wdata[0]) begin
                    pad_model = '0;
                    pad_model[`PAD_BIT_B] = btn_b;
                    pad_model[`PAD_BIT_RIGHT] = btn_right;
                    pad_model[`PAD_BIT_LEFT] = btn_left;
                end else if (wdata[1] && !pad_ctrl_model[1]) begin
                    pad_model = {1'b0, pad_model[15:1]};
                end
                pad_ctrl_model = wdata[1:0];
            end
            default: begin
            end
        endcase
    endtask

    // one CPU access, called and returning on a falling edge
    task automatic bus_access(input periph_pkg::bus_addr_t addr, input logic [3:0] wstrb,
                              input periph_pkg::bus_word_t wdata, input logic hold);
        cpu_address = addr;
        cpu_wstrb = wstrb;
        cpu_write_data = wdata;
        cpu_mem_valid = 1'b1;
        exp_is_read = (wstrb == 4'h0);
        exp_data = expected_read(addr);
        req_start = 1'b1;
        @(negedge vdp_clk);
        req_start = 1'b0;
        while (cpu_mem_ready !== 1'b1) begin
            @(negedge vdp_clk);
        end
        if (wstrb != 4'h0) begin
            model_write(addr, wdata);
        end
        // hold keeps the same request on the bus through the cycle after ready
        if (!hold) begin
            cpu_mem_valid = 1'b0;
        end
        @(negedge vdp_clk);
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count + tb_errors - errors_at_start;
        tests_run = tests_run + 1;
        if (errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
        errors_at_start = error_count + tb_errors;
    endtask

    initial begin
        status_addr = periph_address(`PERIPH_SEL_STATUS, 8'h00);
        dsp_a_addr = periph_address(`PERIPH_SEL_DSP, 8'h00);
        dsp_b_addr = periph_address(`PERIPH_SEL_DSP, 8'h04);
        pad_addr = periph_address(`PERIPH_SEL_PAD, 8'h00);
        none_addr = periph_address(2'd0, 8'h40);
        repeat (2) @(negedge vdp_clk);
        vdp_reset = 1'b0;

        bus_access(status_addr, 4'h0, '0, 1'b0);
        for (n = 0; n < status_writes; n++) begin
            rnd = $random(seed);
            bus_access(status_addr, 4'hf, rnd, 1'b0);
            bus_access(status_addr, 4'h0, '0, 1'b0);
        end
        end_test("status_leds");

        for (n = 0; n < dsp_pairs; n++) begin
            wa = $random(seed);
            wb = $random(seed);
            // -32768 * -32768, then -1234 * -567
            if (n < 2) begin
                wa[15:0] = (n == 0) ? 16'h8000 : 16'hfb2e;
                wb[15:0] = (n == 0) ? 16'h8000 : 16'hfdc9;
            end
            bus_access(dsp_a_addr, 4'hf, wa, 1'b0);
            bus_access(dsp_b_addr, 4'hf, wb, 1'b0);
            bus_access(dsp_a_addr, 4'h0, '0, 1'b0);
        end
        end_test("dsp_mult");

        for (n = 0; n < 2; n++) begin
            rnd = $random(seed);
            btn_b = (n == 0) ? 1'b1 : rnd[0];
            btn_right = (n == 0) ? 1'b1 : rnd[1];
            btn_left = (n == 0) ? 1'b1 : rnd[2];
            bus_access(pad_addr, 4'hf, 32'h1, 1'b0);
            bus_access(pad_addr, 4'hf, 32'h0, 1'b0);
            for (k = 0; k < pad_reads; k++) begin
                bus_access(pad_addr, 4'h0, '0, 1'b0);
                bus_access(pad_addr, 4'hf, 32'h2, 1'b0);
                bus_access(pad_addr, 4'hf, 32'h0, 1'b0);
            end
        end
        end_test("pad_serial");

        bus_access(none_addr, 4'h0, '0, 1'b0);
        bus_access(periph_address(2'd0, 8'hfc), 4'h0, '0, 1'b0);
        bus_access(none_addr, 4'hf, 32'hffff_ffff, 1'b0);
        bus_access(status_addr, 4'h0, '0, 1'b0);
        bus_access(dsp_b_addr, 4'h0, '0, 1'b0);
        bus_access(pad_addr, 4'h0, '0, 1'b0);
        bus_access(none_addr, 4'h0, '0, 1'b0);
        end_test("unmapped_latency");

        ready_base = ready_count;
        for (n = 0; n < burst_len; n++) begin
            bus_access((n == 5) ? dsp_a_addr : status_addr, 4'h0, '0, n != burst_len - 1);
        end
        if (ready_count - ready_base != burst_len) begin
            $display("burst of %0d reads gave %0d ready pulses", burst_len,
                ready_count - ready_base);
            tb_errors = tb_errors + 1;
        end
        end_test("held_valid_burst");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
            check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the access count
    initial begin
        repeat (watchdog_cycles) @(posedge vdp_clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== testbench/periph_checker.sv ====
/*
 * Bus response checker.
 * Times every ready pulse against its request, compares read data
 * with the expected word and watches the two LEDs.
 */

`timescale 1ns/10ps

module periph_checker (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  req_start,
    input  logic                  exp_is_read,
    input  periph_pkg::bus_word_t exp_data,
    input  logic [1:0]            exp_leds,

    input  logic                  cpu_mem_ready,
    input  periph_pkg::bus_word_t cpu_read_data,
    input  logic                  led_r,
    input  logic                  led_b,

    output int                    error_count,
    output int                    check_count,
    output int                    ready_count
);
    logic pending = 1'b0;
    logic read_q = 1'b0;
    logic led_bad = 1'b0;
    periph_pkg::bus_word_t data_q = '0;
    int cycles = 0;

    initial begin
        error_count = 0;
        check_count = 0;
        ready_count = 0;
    end

    // all inputs sampled before the DUT registers update
    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pending = 1'b0;
            cycles = 0;
        end else begin
            cycles = cycles + 1;
            if (cpu_mem_ready) begin
                ready_count = ready_count + 1;
                check_count = check_count + 1;
                if (!pending) begin
                    $display("ready pulse at %0t with no access outstanding", $time);
                    error_count = error_count + 1;
                end else if (cycles != 2) begin
                    $display("ready came %0d cycles after the request instead of 2", cycles);
                    error_count = error_count + 1;
                end else if (read_q && (cpu_read_data !== data_q)) begin
                    $display("ERR cpu_read_data got 0x%08h expected 0x%08h",
                        cpu_read_data, data_q);
                    error_count = error_count + 1;
                end
                pending = 1'b0;
            end

            // new access from the CPU driver
            if (req_start) begin
                if (pending) begin
                    $display("new request at %0t while the last one had no ready", $time);
                    error_count = error_count + 1;
                end
                pending = 1'b1;
                cycles = 0;
                read_q = exp_is_read;
                data_q = exp_data;
            end

            // report a LED mismatch once, not every cycle
            if ({led_b, led_r} !== exp_leds) begin
                if (!led_bad) begin
                    $display("ERR led_b,led_r got 0x%h expected 0x%h", {led_b, led_r}, exp_leds);
                    error_count = error_count + 1;
                end
                led_bad = 1'b1;
            end else begin
                led_bad = 1'b0;
            end
        end
    end

endmodule

// ==== logic/periph_bus.sv ====
/*
 * Peripheral bus top level.
 * CPU request -> decoder -> status regs, DSP, pad reader -> arbiter.
 */

`timescale 1ns/10ps

module periph_bus (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  periph_pkg::bus_addr_t cpu_address,
    input  logic                  cpu_mem_valid,
    input  logic [3:0]            cpu_wstrb,
    input  periph_pkg::bus_word_t cpu_write_data,
    output periph_pkg::bus_word_t cpu_read_data,
    output logic                  cpu_mem_ready,

    input  logic                  btn_left,
    input  logic                  btn_right,
    input  logic                  btn_b,

    output logic                  led_r,
    output logic                  led_b
);
    periph_pkg::periph_sel_t sel;
    logic any_en;
    logic status_en;
    logic status_write_en;
    logic dsp_en;
    logic dsp_write_en;
    logic pad_en;
    logic pad_write_en;
    periph_pkg::bus_addr_t reg_address;
    periph_pkg::bus_word_t reg_write_data;

    periph_pkg::bus_word_t status_read_data;
    periph_pkg::bus_word_t dsp_result;
    logic pad_latch;
    logic pad_clk;
    logic pad_data;

    address_decoder i_decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_address(cpu_address),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .cpu_mem_ready(cpu_mem_ready),
        .sel(sel),
        .any_en(any_en),
        .status_en(status_en),
        .status_write_en(status_write_en),
        .dsp_en(dsp_en),
        .dsp_write_en(dsp_write_en),
        .pad_en(pad_en),
        .pad_write_en(pad_write_en),
        .reg_address(reg_address),
        .reg_write_data(reg_write_data)
    );

    periph_regs i_regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .status_write_en(status_write_en),
        .pad_write_en(pad_write_en),
        .reg_write_data(reg_write_data),
        .led_r(led_r),
        .led_b(led_b),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .status_read_data(status_read_data)
    );

    dsp_mult i_dsp (
        .vdp_clk(vdp_clk),
        .dsp_write_en(dsp_write_en),
        .reg_address(reg_address),
        .reg_write_data(reg_write_data),
        .dsp_result(dsp_result)
    );

    // mock pad driven by the board buttons
    pad_reader i_pad (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .pad_latch(pad_latch),
        .pad_clk(pad_clk),
        .btn_left(btn_left),
        .btn_right(btn_right),
        .btn_b(btn_b),
        .pad_data(pad_data)
    );

    bus_arbiter i_arbiter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .sel(sel),
        .any_en(any_en),
        .status_en(status_en),
        .dsp_en(dsp_en),
        .pad_en(pad_en),
        .status_read_data(status_read_data),
        .dsp_result(dsp_result),
        .pad_data(pad_data),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data)
    );

endmodule

// ==== logic/bus_arbiter.sv ====
/*
 * Peripheral bus arbiter.
 * Returns the selected source's read data together with a single
 * ready pulse one cycle after the decoder enable.
 */

`timescale 1ns/10ps

module bus_arbiter (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,

    input  periph_pkg::periph_sel_t sel,
    input  logic                    any_en,
    input  logic                    status_en,
    input  logic                    dsp_en,
    input  logic                    pad_en,

    input  periph_pkg::bus_word_t   status_read_data,
    input  periph_pkg::bus_word_t   dsp_result,
    input  logic                    pad_data,

    output logic                    cpu_mem_ready,
    output periph_pkg::bus_word_t   cpu_read_data
);
    logic unmapped_en;
    logic ready_next;
    periph_pkg::bus_word_t read_mux;

    // any_en with no select means nobody else will answer
    assign unmapped_en = any_en && (sel == periph_pkg::sel_none);
    assign ready_next = status_en || dsp_en || pad_en || unmapped_en;

    always_comb begin
        case (sel)
            periph_pkg::sel_status: read_mux = status_read_data;
            periph_pkg::sel_dsp: read_mux = dsp_result;
            periph_pkg::sel_pad: read_mux = {31'b0, pad_data};
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
        end else begin
            cpu_mem_ready <= ready_next;
        end
    end

    // only meaningful in the ready cycle
    always_ff @(posedge vdp_clk) begin
        if (ready_next) begin
            cpu_read_data <= read_mux;
        end
    end

    ready_after_enable: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(cpu_mem_ready) |-> $past(any_en));

endmodule

// ==== logic/pad_reader.sv ====
/*
 * Gamepad serial reader.
 * Mocks a pad from three buttons: latch loads the state,
 * each rising pad clock shifts it out one bit at a time.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module pad_reader (
    input  logic vdp_clk,
    input  logic vdp_reset,

    input  logic pad_latch,
    input  logic pad_clk,

    input  logic btn_left,
    input  logic btn_right,
    input  logic btn_b,

    output logic pad_data
);
    logic [2:0] btn_meta;
    logic [2:0] btn_sync;
    logic [`PAD_STATE_BITS-1:0] load_value;
    logic [`PAD_STATE_BITS-1:0] pad_state;
    logic pad_clk_r;
    logic pad_clk_rise;

    // buttons are asynchronous, two flops before use
    always_ff @(posedge vdp_clk) begin
        btn_meta <= {btn_left, btn_right, btn_b};
        btn_sync <= btn_meta;
    end

    always_comb begin
        load_value = '0;
        load_value[`PAD_BIT_B] = btn_sync[0];
        load_value[`PAD_BIT_RIGHT] = btn_sync[1];
        load_value[`PAD_BIT_LEFT] = btn_sync[2];
    end

    assign pad_clk_rise = pad_clk && !pad_clk_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_state <= '0;
            pad_clk_r <= 1'b0;
        end else begin
            pad_clk_r <= pad_clk;
            // latch wins over clock, reloads every cycle while held
            if (pad_latch) begin
                pad_state <= load_value;
            end else if (pad_clk_rise) begin
                pad_state <= {1'b0, pad_state[`PAD_STATE_BITS-1:1]};
            end
        end
    end

    assign pad_data = pad_state[0];

endmodule

// ==== logic/dsp_mult.sv ====
/*
 * DSP multiplier peripheral.
 * Two 16-bit operand registers and a registered signed 32-bit product.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module dsp_mult (
    input  logic                  vdp_clk,

    input  logic                  dsp_write_en,
    input  periph_pkg::bus_addr_t reg_address,
    input  periph_pkg::bus_word_t reg_write_data,

    output periph_pkg::bus_word_t dsp_result
);
    logic signed [15:0] dsp_mult_a;
    logic signed [15:0] dsp_mult_b;
    logic signed [31:0] product;
    logic operand_b_sel;

    assign operand_b_sel = reg_address[`DSP_OPERAND_B_BIT];
    assign product = dsp_mult_a * dsp_mult_b;

    always_ff @(posedge vdp_clk) begin
        // kept as flat ifs so the operands map onto the DSP input registers
        if (dsp_write_en && !operand_b_sel) begin
            dsp_mult_a <= reg_write_data[15:0];
        end

        if (dsp_write_en && operand_b_sel) begin
            dsp_mult_b <= reg_write_data[15:0];
        end

        // output register of the multiplier
        dsp_result <= product;
    end

endmodule

// ==== logic/periph_regs.sv ====
/*
 * Status and pad control registers.
 * Status drives the two LEDs, pad control drives the gamepad lines.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module periph_regs (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  status_write_en,
    input  logic                  pad_write_en,
    input  periph_pkg::bus_word_t reg_write_data,

    output logic                  led_r,
    output logic                  led_b,
    output logic                  pad_latch,
    output logic                  pad_clk,
    output periph_pkg::bus_word_t status_read_data
);
    // bit 0 red, bit 1 blue
    logic [1:0] status;
    // bit 0 latch, bit 1 clock
    logic [1:0] pad_ctrl;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `STATUS_RESET_VALUE;
            pad_ctrl <= 2'b00;
        end else begin
            if (status_write_en) begin
                status <= reg_write_data[1:0];
            end
            if (pad_write_en) begin
                pad_ctrl <= reg_write_data[1:0];
            end
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    assign status_read_data = {30'b0, status};

endmodule

// ==== logic/address_decoder.sv ====
/*
 * Address decoder.
 * Registers the CPU request and emits a single enable pulse per access,
 * held off by a busy flag until the bus returns ready.
 */

`timescale 1ns/10ps

`include "periph_consts.svh"

module address_decoder (
    input  logic                    vdp_clk,
    input  logic                    vdp_reset,

    input  periph_pkg::bus_addr_t   cpu_address,
    input  logic                    cpu_mem_valid,
    input  logic [3:0]              cpu_wstrb,
    input  periph_pkg::bus_word_t   cpu_write_data,
    input  logic                    cpu_mem_ready,

    output periph_pkg::periph_sel_t sel,
    output logic                    any_en,
    output logic                    status_en,
    output logic                    status_write_en,
    output logic                    dsp_en,
    output logic                    dsp_write_en,
    output logic                    pad_en,
    output logic                    pad_write_en,
    output periph_pkg::bus_addr_t   reg_address,
    output periph_pkg::bus_word_t   reg_write_data
);
    logic busy;
    logic accept;
    logic write_req;
    logic [1:0] sel_field;
    periph_pkg::periph_sel_t sel_next;

    assign sel_field = cpu_address[`PERIPH_SEL_LSB +: 2];
    assign write_req = |cpu_wstrb;
    // new request only once the previous one has seen ready
    assign accept = cpu_mem_valid && !busy;

    always_comb begin
        case (sel_field)
            `PERIPH_SEL_STATUS: sel_next = periph_pkg::sel_status;
            `PERIPH_SEL_DSP: sel_next = periph_pkg::sel_dsp;
            `PERIPH_SEL_PAD: sel_next = periph_pkg::sel_pad;
            default: sel_next = periph_pkg::sel_none;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy <= 1'b0;
            sel <= periph_pkg::sel_none;
            any_en <= 1'b0;
            status_en <= 1'b0;
            status_write_en <= 1'b0;
            dsp_en <= 1'b0;
            dsp_write_en <= 1'b0;
            pad_en <= 1'b0;
            pad_write_en <= 1'b0;
        end else begin
            any_en <= accept;
            status_en <= accept && (sel_next == periph_pkg::sel_status);
            status_write_en <= accept && write_req && (sel_next == periph_pkg::sel_status);
            dsp_en <= accept && (sel_next == periph_pkg::sel_dsp);
            dsp_write_en <= accept && write_req && (sel_next == periph_pkg::sel_dsp);
            pad_en <= accept && (sel_next == periph_pkg::sel_pad);
            pad_write_en <= accept && write_req && (sel_next == periph_pkg::sel_pad);

            if (accept) begin
                busy <= 1'b1;
                sel <= sel_next;
            end else if (cpu_mem_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // request payload, captured with the pulse
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            reg_address <= cpu_address;
            reg_write_data <= cpu_write_data;
        end
    end

    // ready only ever answers an access still in flight
    ready_while_busy: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        cpu_mem_ready |-> busy);

endmodule

// ==== logic/periph_pkg.sv ====
/*
 * Peripheral bus types.
 * Select encoding and CPU bus word types shared across the block.
 */

package periph_pkg;

    // which peripheral an access targets
    typedef enum logic [1:0] {
        sel_none = 2'd0,
        sel_status = 2'd1,
        sel_dsp = 2'd2,
        sel_pad = 2'd3
    } periph_sel_t;

    // cpu data word
    typedef logic [31:0] bus_word_t;

    // cpu byte address
    typedef logic [23:0] bus_addr_t;

endpackage

// ==== logic/periph_consts.svh ====
/*
 * Peripheral block constants.
 * Address map of the select field, register offsets and reset values.
 */

`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// select field sits in address bits 21:20
`define PERIPH_SEL_LSB 20

// select field values, zero is unmapped
`define PERIPH_SEL_STATUS 2'd1
`define PERIPH_SEL_DSP 2'd2
`define PERIPH_SEL_PAD 2'd3

// operand b lives at offset 4 inside the dsp window
`define DSP_OPERAND_B_BIT 2

// red led on out of reset
`define STATUS_RESET_VALUE 2'b01

// serial pad state
`define PAD_STATE_BITS 16

// button positions in the pad word
`define PAD_BIT_B 0
`define PAD_BIT_RIGHT 6
`define PAD_BIT_LEFT 7

`endif
